/* logic/i3c_dxt_defs.svh */
// Table depths, register window base addresses and AXI4-Lite address width
// for the DAT/DCT access subsystem
`ifndef I3C_DXT_DEFS_SVH
`define I3C_DXT_DEFS_SVH

// Device Address Table, 64-bit entries
`define DAT_DEPTH 128

// Device Context Table, 128-bit entries
`define DCT_DEPTH 128

// Byte base of the DAT window, 8 bytes per entry
`define DAT_BASE 'h400

// Byte base of the DCT window, 16 bytes per entry
`define DCT_BASE 'h800

// AXI4-Lite byte address width
`define AXIL_AW 12

`endif

/* logic/i3c_dxt_pkg.sv */
// Entry, software request/response and memory port types for DAT/DCT access,
// plus the AXI response codes
package i3c_dxt_pkg;

  `include "i3c_dxt_defs.svh"

  // Index widths, the software index is wide enough for either table
  localparam int unsigned DatAw = $clog2(`DAT_DEPTH);
  localparam int unsigned DctAw = $clog2(`DCT_DEPTH);
  localparam int unsigned IdxW = (DatAw > DctAw) ? DatAw : DctAw;

  typedef logic [63:0] dat_entry_t;
  typedef logic [127:0] dct_entry_t;

  typedef enum logic {
    TBL_DAT = 1'b0,
    TBL_DCT = 1'b1
  } tbl_sel_e;

  // One software access, word selects a 32-bit slice of the entry
  typedef struct packed {
    logic valid;
    tbl_sel_e tbl;
    logic write;
    logic [IdxW-1:0] index;
    logic [1:0] word;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic rd_ack;
    logic wr_ack;
    logic err;
    logic [31:0] rdata;
  } csr_rsp_t;

  typedef struct packed {
    logic req;
    logic write;
    logic [DatAw-1:0] addr;
    dat_entry_t wdata;
    dat_entry_t wmask;
  } dat_mem_req_t;

  typedef struct packed {
    logic req;
    logic write;
    logic [DctAw-1:0] addr;
    dct_entry_t wdata;
    dct_entry_t wmask;
  } dct_mem_req_t;

  typedef enum logic [1:0] {
    AXIL_OKAY = 2'b00,
    AXIL_SLVERR = 2'b10,
    AXIL_DECERR = 2'b11
  } axil_resp_e;

endpackage

/* logic/dxt_table_ram.sv */
// Bit-masked write table memory with registered read
`timescale 1ns/100ps

module dxt_table_ram #(
  parameter type entry_t = i3c_dxt_pkg::dat_entry_t,
  parameter type req_t = i3c_dxt_pkg::dat_mem_req_t,
  parameter int unsigned DEPTH = 128
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  req_t   req_i,
  output entry_t rdata_o
);

  entry_t mem [DEPTH];

  // Table contents start out cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (req_i.req && req_i.write) begin
      mem[req_i.addr] <= (mem[req_i.addr] & ~req_i.wmask) | (req_i.wdata & req_i.wmask);
    end
  end

  // Read returns the old entry on a same-cycle write
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_o <= mem[req_i.addr];
    end
  end

endmodule

/* logic/axil_csr_decode.sv */
// AXI4-Lite AW/W/AR acceptance and DAT/DCT window decode
`timescale 1ns/100ps
`include "i3c_dxt_defs.svh"

module axil_csr_decode (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  awvalid_i,
  input  logic [`AXIL_AW-1:0]   awaddr_i,
  input  logic                  wvalid_i,
  input  logic [31:0]           wdata_i,
  input  logic                  arvalid_i,
  input  logic [`AXIL_AW-1:0]   araddr_i,
  output logic                  awready_o,
  output logic                  wready_o,
  output logic                  arready_o,
  input  logic                  resp_done_i,
  output i3c_dxt_pkg::csr_req_t csr_req_o,
  output logic                  dec_err_o,
  output logic                  dec_err_wr_o
);
  import i3c_dxt_pkg::*;

  localparam int unsigned DatLo = `DAT_BASE;
  localparam int unsigned DatHi = `DAT_BASE + 8 * `DAT_DEPTH;
  localparam int unsigned DctLo = `DCT_BASE;
  localparam int unsigned DctHi = `DCT_BASE + 16 * `DCT_DEPTH;

  logic busy_q;
  logic wr_go;
  logic rd_go;
  logic accept;
  logic dat_hit;
  logic dct_hit;
  logic [`AXIL_AW-1:0] addr;
  logic [`AXIL_AW-1:0] dat_off;
  logic [`AXIL_AW-1:0] dct_off;
  csr_req_t req_d;

  // AW and W are taken together and win over a same-cycle read
  assign wr_go = ~busy_q & awvalid_i & wvalid_i;
  assign rd_go = ~busy_q & arvalid_i & ~(awvalid_i & wvalid_i);
  assign accept = wr_go | rd_go;

  assign awready_o = wr_go;
  assign wready_o = wr_go;
  assign arready_o = rd_go;

  assign addr = wr_go ? awaddr_i : araddr_i;
  assign dat_hit = (32'(addr) >= DatLo) && (32'(addr) < DatHi);
  assign dct_hit = (32'(addr) >= DctLo) && (32'(addr) < DctHi);
  assign dat_off = addr - `AXIL_AW'(DatLo);
  assign dct_off = addr - `AXIL_AW'(DctLo);

  always_comb begin
    req_d = '0;
    req_d.valid = accept & (dat_hit | dct_hit);
    req_d.write = wr_go;
    req_d.wdata = wdata_i;
    if (dct_hit) begin
      // Bits 3:2 pick the quarter of a 16-byte entry
      req_d.tbl = TBL_DCT;
      req_d.index = IdxW'(dct_off[4 +: DctAw]);
      req_d.word = dct_off[3:2];
    end else begin
      // Bit 2 picks the half of an 8-byte entry
      req_d.tbl = TBL_DAT;
      req_d.index = IdxW'(dat_off[3 +: DatAw]);
      req_d.word = {1'b0, dat_off[2]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      csr_req_o <= '0;
      dec_err_o <= 1'b0;
      dec_err_wr_o <= 1'b0;
    end else begin
      csr_req_o <= req_d;
      dec_err_o <= accept & ~(dat_hit | dct_hit);
      if (accept) begin
        busy_q <= 1'b1;
        dec_err_wr_o <= wr_go;
      end else if (resp_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Completion only arrives for an open transaction
  a_done_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_done_i |-> busy_q);

endmodule

/* logic/dxt.sv */
// DAT/DCT access arbiter with controller priority, software request parking,
// write mask generation and 32-bit word selection
`timescale 1ns/100ps

module dxt (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  i3c_dxt_pkg::csr_req_t                csr_req_i,
  output i3c_dxt_pkg::csr_rsp_t                csr_rsp_o,
  input  logic                                 dat_rd_valid_i,
  input  logic [i3c_dxt_pkg::DatAw-1:0]        dat_index_i,
  output i3c_dxt_pkg::dat_entry_t              dat_rdata_o,
  input  logic                                 dct_rd_valid_i,
  input  logic                                 dct_wr_valid_i,
  input  logic [i3c_dxt_pkg::DctAw-1:0]        dct_index_i,
  input  i3c_dxt_pkg::dct_entry_t              dct_wdata_i,
  output i3c_dxt_pkg::dct_entry_t              dct_rdata_o,
  output i3c_dxt_pkg::dat_mem_req_t            dat_mem_o,
  input  i3c_dxt_pkg::dat_entry_t              dat_mem_i,
  output i3c_dxt_pkg::dct_mem_req_t            dct_mem_o,
  input  i3c_dxt_pkg::dct_entry_t              dct_mem_i
);
  import i3c_dxt_pkg::*;

  // Software access in flight while the RAM read completes
  typedef struct packed {
    logic valid;
    tbl_sel_e tbl;
    logic write;
    logic [1:0] word;
  } sw_stage_t;

  csr_req_t park_q;
  csr_req_t sw_req;
  sw_stage_t s1_q;
  logic collide;
  logic sw_go;
  logic [31:0] word_sel;

  // A parked request is replayed ahead of anything new
  assign sw_req = park_q.valid ? park_q : csr_req_i;

  // Controller owns the table port whenever it touches that table
  assign collide = sw_req.valid &&
                   (((sw_req.tbl == TBL_DAT) && dat_rd_valid_i) ||
                    ((sw_req.tbl == TBL_DCT) && (dct_rd_valid_i || dct_wr_valid_i)));
  assign sw_go = sw_req.valid & ~collide;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      park_q <= '0;
    end else if (collide) begin
      park_q <= sw_req;
    end else begin
      park_q.valid <= 1'b0;
    end
  end

  always_comb begin
    dat_mem_o = '0;
    if (dat_rd_valid_i) begin
      dat_mem_o.req = 1'b1;
      dat_mem_o.addr = dat_index_i;
    end else if (sw_go && (sw_req.tbl == TBL_DAT)) begin
      dat_mem_o.req = 1'b1;
      dat_mem_o.write = sw_req.write;
      dat_mem_o.addr = sw_req.index[DatAw-1:0];
      // Shift data and mask into the selected half
      dat_mem_o.wdata = dat_entry_t'(sw_req.wdata) << {sw_req.word[0], 5'd0};
      dat_mem_o.wmask = dat_entry_t'(32'hffff_ffff) << {sw_req.word[0], 5'd0};
    end
  end

  always_comb begin
    dct_mem_o = '0;
    if (dct_rd_valid_i || dct_wr_valid_i) begin
      dct_mem_o.req = 1'b1;
      dct_mem_o.write = dct_wr_valid_i;
      dct_mem_o.addr = dct_index_i;
      dct_mem_o.wdata = dct_wdata_i;
      dct_mem_o.wmask = '1;
    end else if (sw_go && (sw_req.tbl == TBL_DCT) && !sw_req.write) begin
      // Software writes to the DCT are dropped here
      dct_mem_o.req = 1'b1;
      dct_mem_o.addr = sw_req.index[DctAw-1:0];
    end
  end

  assign dat_rdata_o = dat_mem_i;
  assign dct_rdata_o = dct_mem_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_q <= '0;
    end else begin
      s1_q.valid <= sw_go;
      s1_q.tbl <= sw_req.tbl;
      s1_q.write <= sw_req.write;
      s1_q.word <= sw_req.word;
    end
  end

  assign word_sel = (s1_q.tbl == TBL_DAT) ? dat_mem_i[{s1_q.word[0], 5'd0} +: 32]
                                          : dct_mem_i[{s1_q.word, 5'd0} +: 32];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_rsp_o <= '0;
    end else begin
      csr_rsp_o.rd_ack <= s1_q.valid & ~s1_q.write;
      csr_rsp_o.wr_ack <= s1_q.valid & s1_q.write;
      csr_rsp_o.err <= s1_q.valid & s1_q.write & (s1_q.tbl == TBL_DCT);
      csr_rsp_o.rdata <= (s1_q.valid && !s1_q.write) ? word_sel : '0;
    end
  end

  // Decode holds off new requests until the parked one has completed
  a_no_req_while_parked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    park_q.valid |-> !csr_req_i.valid);

endmodule

/* logic/axil_resp_gen.sv */
// AXI4-Lite B and R channel holding registers
`timescale 1ns/100ps

module axil_resp_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  i3c_dxt_pkg::csr_rsp_t   csr_rsp_i,
  input  logic                    dec_err_i,
  input  logic                    dec_err_wr_i,
  input  logic                    bready_i,
  input  logic                    rready_i,
  output logic                    bvalid_o,
  output i3c_dxt_pkg::axil_resp_e bresp_o,
  output logic                    rvalid_o,
  output logic [31:0]             rdata_o,
  output i3c_dxt_pkg::axil_resp_e rresp_o,
  output logic                    resp_done_o
);
  import i3c_dxt_pkg::*;

  logic b_load;
  logic r_load;

  assign b_load = csr_rsp_i.wr_ack | (dec_err_i & dec_err_wr_i);
  assign r_load = csr_rsp_i.rd_ack | (dec_err_i & ~dec_err_wr_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      if (b_load) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (r_load) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  // Beat contents, held until the handshake
  always_ff @(posedge clk_i) begin
    if (b_load) begin
      bresp_o <= dec_err_i ? AXIL_DECERR : (csr_rsp_i.err ? AXIL_SLVERR : AXIL_OKAY);
    end
    if (r_load) begin
      rresp_o <= dec_err_i ? AXIL_DECERR : AXIL_OKAY;
      rdata_o <= dec_err_i ? '0 : csr_rsp_i.rdata;
    end
  end

  assign resp_done_o = (bvalid_o & bready_i) | (rvalid_o & rready_i);

  // Only one transaction is ever outstanding
  a_one_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bvalid_o && rvalid_o));

endmodule

/* logic/i3c_dxt_top.sv */
// DAT/DCT access subsystem top with AXI4-Lite slave and controller ports
`timescale 1ns/100ps
`include "i3c_dxt_defs.svh"

module i3c_dxt_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [`AXIL_AW-1:0]           awaddr_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  input  logic [31:0]                   wdata_i,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  output i3c_dxt_pkg::axil_resp_e       bresp_o,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  input  logic [`AXIL_AW-1:0]           araddr_i,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  output logic [31:0]                   rdata_o,
  output i3c_dxt_pkg::axil_resp_e       rresp_o,
  input  logic                          dat_rd_valid_i,
  input  logic [i3c_dxt_pkg::DatAw-1:0] dat_index_i,
  output i3c_dxt_pkg::dat_entry_t       dat_rdata_o,
  input  logic                          dct_rd_valid_i,
  input  logic                          dct_wr_valid_i,
  input  logic [i3c_dxt_pkg::DctAw-1:0] dct_index_i,
  input  i3c_dxt_pkg::dct_entry_t       dct_wdata_i,
  output i3c_dxt_pkg::dct_entry_t       dct_rdata_o
);
  import i3c_dxt_pkg::*;

  csr_req_t csr_req;
  csr_rsp_t csr_rsp;
  logic dec_err;
  logic dec_err_wr;
  logic resp_done;
  dat_mem_req_t dat_mem_req;
  dat_entry_t dat_mem_rdata;
  dct_mem_req_t dct_mem_req;
  dct_entry_t dct_mem_rdata;

  axil_csr_decode u_decode (
    .clk_i, .rst_ni, .awvalid_i, .awaddr_i, .wvalid_i, .wdata_i, .arvalid_i, .araddr_i,
    .awready_o, .wready_o, .arready_o,
    .resp_done_i(resp_done), .csr_req_o(csr_req),
    .dec_err_o(dec_err), .dec_err_wr_o(dec_err_wr)
  );

  dxt u_dxt (
    .clk_i, .rst_ni, .csr_req_i(csr_req), .csr_rsp_o(csr_rsp),
    .dat_rd_valid_i, .dat_index_i, .dat_rdata_o,
    .dct_rd_valid_i, .dct_wr_valid_i, .dct_index_i, .dct_wdata_i, .dct_rdata_o,
    .dat_mem_o(dat_mem_req), .dat_mem_i(dat_mem_rdata),
    .dct_mem_o(dct_mem_req), .dct_mem_i(dct_mem_rdata)
  );

  dxt_table_ram #(.entry_t(dat_entry_t), .req_t(dat_mem_req_t), .DEPTH(`DAT_DEPTH)) u_dat_ram (
    .clk_i, .rst_ni, .req_i(dat_mem_req), .rdata_o(dat_mem_rdata)
  );

  dxt_table_ram #(.entry_t(dct_entry_t), .req_t(dct_mem_req_t), .DEPTH(`DCT_DEPTH)) u_dct_ram (
    .clk_i, .rst_ni, .req_i(dct_mem_req), .rdata_o(dct_mem_rdata)
  );

  axil_resp_gen u_resp (
    .clk_i, .rst_ni, .csr_rsp_i(csr_rsp), .dec_err_i(dec_err), .dec_err_wr_i(dec_err_wr),
    .bready_i, .rready_i, .bvalid_o, .bresp_o, .rvalid_o, .rdata_o, .rresp_o,
    .resp_done_o(resp_done)
  );

endmodule

/* tb/tb_i3c_dxt.sv */
// Testbench for the DAT/DCT access subsystem with AXI4-Lite and controller
// drivers, reference tables and checks
`timescale 1ns/100ps
`include "i3c_dxt_defs.svh"

module tb_i3c_dxt;
  import i3c_dxt_pkg::*;

  localparam int Tmo = 200;

  logic clk_i;
  logic rst_ni;
  logic awvalid_i;
  logic awready_o;
  logic [`AXIL_AW-1:0] awaddr_i;
  logic wvalid_i;
  logic wready_o;
  logic [31:0] wdata_i;
  logic bvalid_o;
  logic bready_i;
  axil_resp_e bresp_o;
  logic arvalid_i;
  logic arready_o;
  logic [`AXIL_AW-1:0] araddr_i;
  logic rvalid_o;
  logic rready_i;
  logic [31:0] rdata_o;
  axil_resp_e rresp_o;
  logic dat_rd_valid_i;
  logic [DatAw-1:0] dat_index_i;
  dat_entry_t dat_rdata_o;
  logic dct_rd_valid_i;
  logic dct_wr_valid_i;
  logic [DctAw-1:0] dct_index_i;
  dct_entry_t dct_wdata_i;
  dct_entry_t dct_rdata_o;

  // Reference tables
  logic [63:0] dat_model [128];
  logic [127:0] dct_model [128];
  int seed;
  int errors;
  int err_base;
  int tests;
  logic stop;

  i3c_dxt_top DUT (.*);

  always #20 clk_i = ~clk_i;

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
    errors++;
    $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout: no %0s within %0d cycles at %0t ns", what, Tmo, $time);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %0d, %0s: %0d errors", tests, name, errors - err_base);
    err_base = errors;
  endtask

  function automatic logic beat_valid(input logic is_wr);
    return is_wr ? bvalid_o : rvalid_o;
  endfunction

  // Wait for B or R, hold ready low for a stretch, then take the beat
  task automatic wait_beat(input logic is_wr, input int stall, output axil_resp_e resp,
                           output logic [31:0] data);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!beat_valid(is_wr) && n < Tmo);
    if (!beat_valid(is_wr)) timeout_abort(is_wr ? "B valid" : "R valid");
    for (int i = 0; i < stall; i++) begin
      @(negedge clk_i);
      if (!beat_valid(is_wr)) begin
        errors++;
        $display("Response valid dropped before ready at %0t ns", $time);
      end
    end
    @(posedge clk_i);
    if (is_wr) bready_i <= 1'b1;
    else rready_i <= 1'b1;
    @(negedge clk_i);
    resp = is_wr ? bresp_o : rresp_o;
    data = rdata_o;
    @(posedge clk_i);
    bready_i <= 1'b0;
    rready_i <= 1'b0;
    @(negedge clk_i);
    if (beat_valid(is_wr)) begin
      errors++;
      $display("Response valid still high after handshake at %0t ns", $time);
    end
  endtask

  task automatic axi_write(input logic [`AXIL_AW-1:0] addr, input logic [31:0] data,
                           input int stall, output axil_resp_e resp);
    int n;
    logic [31:0] unused;
    @(posedge clk_i);
    awvalid_i <= 1'b1;
    awaddr_i <= addr;
    wvalid_i <= 1'b1;
    wdata_i <= data;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!(awready_o && wready_o) && n < Tmo);
    if (!(awready_o && wready_o)) timeout_abort("AW/W handshake");
    @(posedge clk_i);
    awvalid_i <= 1'b0;
    wvalid_i <= 1'b0;
    wait_beat(1'b1, stall, resp, unused);
  endtask

  task automatic axi_read(input logic [`AXIL_AW-1:0] addr, input int stall,
                          output logic [31:0] data, output axil_resp_e resp);
    int n;
    @(posedge clk_i);
    arvalid_i <= 1'b1;
    araddr_i <= addr;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!arready_o && n < Tmo);
    if (!arready_o) timeout_abort("AR handshake");
    @(posedge clk_i);
    arvalid_i <= 1'b0;
    wait_beat(1'b0, stall, resp, data);
  endtask

  task automatic sw_read(input tbl_sel_e tbl, input int idx, input int word, input int stall);
    logic [`AXIL_AW-1:0] addr;
    logic [31:0] exp;
    logic [31:0] got;
    axil_resp_e resp;
    if (tbl == TBL_DAT) begin
      addr = `AXIL_AW'(`DAT_BASE + idx * 8 + (word % 2) * 4);
      exp = dat_model[idx][(word % 2) * 32 +: 32];
    end else begin
      addr = `AXIL_AW'(`DCT_BASE + idx * 16 + word * 4);
      exp = dct_model[idx][word * 32 +: 32];
    end
    axi_read(addr, stall, got, resp);
    if (got !== exp) report_mismatch("rdata_o", exp, got);
    if (resp !== AXIL_OKAY) report_mismatch("rresp_o", AXIL_OKAY, resp);
  endtask

  task automatic sw_dat_write(input int idx, input int half, input logic [31:0] data,
                              input int stall);
    axil_resp_e resp;
    axi_write(`AXIL_AW'(`DAT_BASE + idx * 8 + half * 4), data, stall, resp);
    dat_model[idx][half * 32 +: 32] = data;
    if (resp !== AXIL_OKAY) report_mismatch("bresp_o", AXIL_OKAY, resp);
  endtask

  // Whole entry is due one cycle after the valid
  task automatic ctrl_read(input tbl_sel_e tbl, input int idx);
    @(posedge clk_i);
    dat_rd_valid_i <= (tbl == TBL_DAT);
    dct_rd_valid_i <= (tbl == TBL_DCT);
    dat_index_i <= DatAw'(idx);
    dct_index_i <= DctAw'(idx);
    @(posedge clk_i);
    dat_rd_valid_i <= 1'b0;
    dct_rd_valid_i <= 1'b0;
    @(negedge clk_i);
    if (tbl == TBL_DAT && dat_rdata_o !== dat_model[idx]) begin
      report_mismatch("dat_rdata_o", dat_model[idx], dat_rdata_o);
    end
    if (tbl == TBL_DCT && dct_rdata_o !== dct_model[idx]) begin
      report_mismatch("dct_rdata_o", dct_model[idx], dct_rdata_o);
    end
  endtask

  task automatic ctrl_dct_write(input int idx, input logic [127:0] data);
    @(posedge clk_i);
    dct_wr_valid_i <= 1'b1;
    dct_index_i <= DctAw'(idx);
    dct_wdata_i <= data;
    @(posedge clk_i);
    dct_wr_valid_i <= 1'b0;
    dct_model[idx] = data;
  endtask

  // Random controller reads on the low half of both tables until stop
  task automatic ctrl_noise();
    logic pend_v;
    tbl_sel_e pend_t;
    int pend_i;
    logic cur_v;
    tbl_sel_e cur_t;
    int cur_i;
    pend_v = 1'b0;
    pend_t = TBL_DAT;
    pend_i = 0;
    while (!stop || pend_v) begin
      @(posedge clk_i);
      cur_v = !stop && (($random(seed) & 3) != 0);
      cur_t = ($random(seed) & 1) ? TBL_DCT : TBL_DAT;
      cur_i = $random(seed) & 63;
      dat_rd_valid_i <= cur_v && (cur_t == TBL_DAT);
      dct_rd_valid_i <= cur_v && (cur_t == TBL_DCT);
      dat_index_i <= DatAw'(cur_i);
      dct_index_i <= DctAw'(cur_i);
      @(negedge clk_i);
      if (pend_v && pend_t == TBL_DAT && dat_rdata_o !== dat_model[pend_i]) begin
        report_mismatch("dat_rdata_o", dat_model[pend_i], dat_rdata_o);
      end
      if (pend_v && pend_t == TBL_DCT && dct_rdata_o !== dct_model[pend_i]) begin
        report_mismatch("dct_rdata_o", dct_model[pend_i], dct_rdata_o);
      end
      pend_v = cur_v;
      pend_t = cur_t;
      pend_i = cur_i;
    end
  endtask

  initial begin
    int idx;
    int half;
    logic [31:0] rd;
    axil_resp_e resp;
    int dat_idx_q[$];
    int dat_half_q[$];
    int dct_idx_q[$];
    seed = 90;
    errors = 0;
    err_base = 0;
    tests = 0;
    stop = 1'b0;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    awvalid_i = 1'b0;
    awaddr_i = '0;
    wvalid_i = 1'b0;
    wdata_i = '0;
    bready_i = 1'b0;
    arvalid_i = 1'b0;
    araddr_i = '0;
    rready_i = 1'b0;
    dat_rd_valid_i = 1'b0;
    dat_index_i = '0;
    dct_rd_valid_i = 1'b0;
    dct_wr_valid_i = 1'b0;
    dct_index_i = '0;
    dct_wdata_i = '0;
    for (int i = 0; i < 128; i++) begin
      dat_model[i] = '0;
      dct_model[i] = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < 24; i++) begin
      idx = $random(seed) & 127;
      half = $random(seed) & 1;
      sw_dat_write(idx, half, $random(seed), 0);
      dat_idx_q.push_back(idx);
      dat_half_q.push_back(half);
    end
    foreach (dat_idx_q[i]) sw_read(TBL_DAT, dat_idx_q[i], dat_half_q[i], 0);
    finish_test("DAT software access");

    for (int i = 0; i < 8; i++) begin
      idx = $random(seed) & 127;
      ctrl_dct_write(idx, {$random(seed), $random(seed), $random(seed), $random(seed)});
      dct_idx_q.push_back(idx);
    end
    foreach (dct_idx_q[i]) begin
      for (int w = 0; w < 4; w++) sw_read(TBL_DCT, dct_idx_q[i], w, 0);
    end
    finish_test("DCT controller write, software read");

    foreach (dat_idx_q[i]) ctrl_read(TBL_DAT, dat_idx_q[i]);
    foreach (dct_idx_q[i]) ctrl_read(TBL_DCT, dct_idx_q[i]);
    finish_test("Controller reads");

    // Entry must survive the rejected write
    axi_write(`AXIL_AW'(`DCT_BASE + dct_idx_q[0] * 16 + 4), $random(seed), 0, resp);
    if (resp !== AXIL_SLVERR) report_mismatch("bresp_o", AXIL_SLVERR, resp);
    sw_read(TBL_DCT, dct_idx_q[0], 1, 0);
    ctrl_read(TBL_DCT, dct_idx_q[0]);
    finish_test("Software DCT write");

    axi_write(`AXIL_AW'('h100), $random(seed), 0, resp);
    if (resp !== AXIL_DECERR) report_mismatch("bresp_o", AXIL_DECERR, resp);
    axi_read(`AXIL_AW'('h3fc), 0, rd, resp);
    if (resp !== AXIL_DECERR) report_mismatch("rresp_o", AXIL_DECERR, resp);
    if (rd !== 32'h0) report_mismatch("rdata_o", 32'h0, rd);
    axi_read(`AXIL_AW'('h000), 0, rd, resp);
    if (resp !== AXIL_DECERR) report_mismatch("rresp_o", AXIL_DECERR, resp);
    if (rd !== 32'h0) report_mismatch("rdata_o", 32'h0, rd);
    finish_test("Unmapped addresses");

    // Software writes stay above index 63, out of reach of the controller reads
    fork
      begin
        for (int i = 0; i < 30; i++) begin
          if ($random(seed) & 1) begin
            sw_read(($random(seed) & 1) ? TBL_DCT : TBL_DAT, $random(seed) & 127,
                    $random(seed) & 3, $random(seed) & 3);
          end else begin
            sw_dat_write(64 + ($random(seed) & 63), $random(seed) & 1, $random(seed),
                         $random(seed) & 3);
          end
        end
        stop = 1'b1;
      end
      ctrl_noise();
    join
    finish_test("Collisions and back-pressure");

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+logic
logic/i3c_dxt_pkg.sv
logic/dxt_table_ram.sv
logic/axil_csr_decode.sv
logic/dxt.sv
logic/axil_resp_gen.sv
logic/i3c_dxt_top.sv
tb/tb_i3c_dxt.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the DAT/DCT testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_i3c_dxt -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_i3c_dxt > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation executable returned status $status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
